// File: source/queue_pkg.sv
package queue_pkg;

	// field widths
	localparam int STATUS_W   = 6;
	localparam int PTR_W      = 7;
	localparam int READ_NUM_W = 10;
	localparam int POS_W      = 7;
	localparam int QUERY_W    = 8;
	localparam int IK_W       = 64;
	localparam int IK_KEEP    = 33;  // stored interval bits
	localparam int INFO_LO_W  = 7;   // each kept slice of ik_info

	localparam int ALIGN_STAGES = 3;   // read RAM latency
	localparam int READ_Q_DEPTH = 256;
	localparam int OCC_Q_DEPTH  = 32;

	// status codes
	localparam logic [STATUS_W-1:0] F_INIT  = 6'd0;
	localparam logic [STATUS_W-1:0] F_RUN   = 6'd1;
	localparam logic [STATUS_W-1:0] F_BREAK = 6'd2;
	localparam logic [STATUS_W-1:0] DONE    = 6'h20;
	localparam logic [STATUS_W-1:0] BUBBLE  = 6'h30;

	// filler patterns for bubbles and unused occ outputs
	localparam logic [15:0]        NARROW_FILL = '1;
	localparam logic [IK_W-1:0]    IK_FILL     = 64'h1111_1111_1111_1111;
	localparam logic [31:0]        CNT32_FILL  = 32'h1111_1111;
	localparam logic [63:0]        CNT64_FILL  = 64'h1111_1111_1111_1111;
	localparam logic [QUERY_W-1:0] QUERY_NONE  = '1;

	typedef struct packed {
		logic [STATUS_W-1:0]   status;
		logic [PTR_W-1:0]      ptr_curr;
		logic [READ_NUM_W-1:0] read_num;
		logic [IK_W-1:0]       ik_x0;
		logic [IK_W-1:0]       ik_x1;
		logic [IK_W-1:0]       ik_x2;
		logic [IK_W-1:0]       ik_info;
		logic [POS_W-1:0]      forward_i;
		logic [POS_W-1:0]      min_intv;
		logic [POS_W-1:0]      backward_x;
	} fwd_state_t;

	typedef struct packed {
		fwd_state_t         state;
		logic [QUERY_W-1:0] query;  // next base from read RAM
	} fwd_out_t;

	// compressed form kept in the read queue
	typedef struct packed {
		logic [STATUS_W-1:0]   status;
		logic [PTR_W-1:0]      ptr_curr;
		logic [READ_NUM_W-1:0] read_num;
		logic [IK_KEEP-1:0]    ik_x0;
		logic [IK_KEEP-1:0]    ik_x1;
		logic [IK_KEEP-1:0]    ik_x2;
		logic [INFO_LO_W-1:0]  info_hi;  // ik_info from bit 32
		logic [INFO_LO_W-1:0]  info_lo;
		logic [POS_W-1:0]      forward_i;
		logic [POS_W-1:0]      min_intv;
		logic [POS_W-1:0]      backward_x;
		logic [QUERY_W-1:0]    query;
	} read_entry_t;

	typedef struct packed {
		logic [3:0][31:0] cnt_a;
		logic [3:0][63:0] cnt_b;
		logic [3:0][31:0] cntl_a;
		logic [3:0][63:0] cntl_b;
	} occ_block_t;

	typedef struct packed {
		logic [READ_NUM_W-1:0] read_num;
		logic [IK_W-1:0]       ik_x0;
		logic [IK_W-1:0]       ik_x1;
		logic [IK_W-1:0]       ik_x2;
		logic [IK_W-1:0]       ik_info;
		logic [POS_W-1:0]      forward_i;
	} new_read_t;

	function automatic read_entry_t pack_entry(fwd_state_t s, logic [QUERY_W-1:0] base);
		read_entry_t e;
		e.status     = s.status;
		e.ptr_curr   = s.ptr_curr;
		e.read_num   = s.read_num;
		e.ik_x0      = s.ik_x0[IK_KEEP-1:0];
		e.ik_x1      = s.ik_x1[IK_KEEP-1:0];
		e.ik_x2      = s.ik_x2[IK_KEEP-1:0];
		e.info_hi    = s.ik_info[IK_W/2 +: INFO_LO_W];
		e.info_lo    = s.ik_info[INFO_LO_W-1:0];
		e.forward_i  = s.forward_i;
		e.min_intv   = s.min_intv;
		e.backward_x = s.backward_x;
		e.query      = base;
		return e;
	endfunction

	// dropped high bits come back as zeros
	function automatic fwd_out_t unpack_entry(read_entry_t e);
		fwd_out_t o;
		o = '0;
		o.state.status                        = e.status;
		o.state.ptr_curr                      = e.ptr_curr;
		o.state.read_num                      = e.read_num;
		o.state.ik_x0[IK_KEEP-1:0]            = e.ik_x0;
		o.state.ik_x1[IK_KEEP-1:0]            = e.ik_x1;
		o.state.ik_x2[IK_KEEP-1:0]            = e.ik_x2;
		o.state.ik_info[IK_W/2 +: INFO_LO_W]  = e.info_hi;
		o.state.ik_info[INFO_LO_W-1:0]        = e.info_lo;
		o.state.forward_i                     = e.forward_i;
		o.state.min_intv                      = e.min_intv;
		o.state.backward_x                    = e.backward_x;
		o.query                               = e.query;
		return o;
	endfunction

endpackage

// File: source/query_align.sv
`timescale 1ns/1ps

module query_align (
	input  logic                                    Clk_32UI,
	input  queue_pkg::fwd_state_t                   fwd_in,
	input  logic [queue_pkg::QUERY_W-1:0]           next_query_position,
	input  logic [queue_pkg::QUERY_W-1:0]           query_base,

	output logic [queue_pkg::QUERY_W-1:0]           query_position_ram,
	output logic [queue_pkg::READ_NUM_W-1:0]        query_read_num_ram,
	output logic [queue_pkg::STATUS_W-1:0]          query_status_ram,

	output queue_pkg::read_entry_t                  entry,
	output logic                                    entry_push
);

	logic need_query;

	// states waiting for the RAM answer
	queue_pkg::fwd_state_t dly [queue_pkg::ALIGN_STAGES];

	// --------------------
	// query request
	// --------------------

	// break reads and bubbles ask nothing of the RAM
	assign need_query = (fwd_in.status != queue_pkg::BUBBLE) &&
		(fwd_in.status != queue_pkg::F_BREAK);

	always_comb begin
		if (need_query) begin
			query_position_ram = next_query_position;
			query_read_num_ram = fwd_in.read_num;
			query_status_ram   = fwd_in.status;
		end else begin
			query_position_ram = '1;
			query_read_num_ram = '1;
			query_status_ram   = '1;
		end
	end

	// --------------------
	// alignment line
	// --------------------

	always_ff @(posedge Clk_32UI) begin
		dly[0] <= fwd_in;
		for (int i = 1; i < queue_pkg::ALIGN_STAGES; i++) begin
			dly[i] <= dly[i-1];
		end
		// base for dly[last] is on query_base right now
		entry <= queue_pkg::pack_entry(dly[queue_pkg::ALIGN_STAGES-1], query_base);
	end

	// only live forward states are parked
	always_comb begin
		case (entry.status)
			queue_pkg::F_INIT,
			queue_pkg::F_RUN,
			queue_pkg::F_BREAK: entry_push = 1'b1;
			default:            entry_push = 1'b0;  // bubble, done, unknown
		endcase
	end

endmodule

// File: source/circular_queue.sv
`timescale 1ns/1ps

module circular_queue #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 32
) (
	input  logic     Clk_32UI,
	input  logic     reset_n,
	input  logic     push,
	input  logic     pop,
	input  payload_t din,

	output payload_t head,
	output logic     not_empty
);

	// DEPTH is a power of two, pointers wrap on their own
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;

	payload_t mem [DEPTH];

	always_ff @(posedge Clk_32UI) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	assign head      = mem[rd_ptr];  // oldest entry
	assign not_empty = (wr_ptr != rd_ptr);

endmodule

// File: source/read_dispatch.sv
`timescale 1ns/1ps

module read_dispatch (
	input  logic                      Clk_32UI,
	input  logic                      reset_n,
	input  logic                      stall,

	input  queue_pkg::read_entry_t    read_head,
	input  logic                      read_ready,
	input  logic                      occ_ready,
	input  queue_pkg::occ_block_t     occ_head,

	input  logic                      new_read_valid,
	input  logic                      load_done,
	input  queue_pkg::new_read_t      new_read_in,

	output logic                      read_pop,
	output logic                      occ_pop,
	output logic                      new_read,
	output queue_pkg::fwd_out_t       fwd_out,
	output queue_pkg::occ_block_t     occ_out
);

	logic head_break;
	logic take_pair;
	logic take_fresh;

	queue_pkg::fwd_out_t   next_fwd;
	queue_pkg::occ_block_t next_occ;

	// --------------------
	// filler records
	// --------------------

	function automatic queue_pkg::fwd_out_t bubble_rec();
		queue_pkg::fwd_out_t b;
		b.state.status     = queue_pkg::BUBBLE;
		b.state.ptr_curr   = queue_pkg::NARROW_FILL[queue_pkg::PTR_W-1:0];
		b.state.read_num   = queue_pkg::NARROW_FILL[queue_pkg::READ_NUM_W-1:0];
		b.state.ik_x0      = queue_pkg::IK_FILL;
		b.state.ik_x1      = queue_pkg::IK_FILL;
		b.state.ik_x2      = queue_pkg::IK_FILL;
		b.state.ik_info    = queue_pkg::IK_FILL;
		b.state.forward_i  = queue_pkg::NARROW_FILL[queue_pkg::POS_W-1:0];
		b.state.min_intv   = queue_pkg::NARROW_FILL[queue_pkg::POS_W-1:0];
		b.state.backward_x = queue_pkg::NARROW_FILL[queue_pkg::POS_W-1:0];
		b.query            = queue_pkg::QUERY_NONE;
		return b;
	endfunction

	function automatic queue_pkg::occ_block_t occ_fill();
		queue_pkg::occ_block_t f;
		for (int k = 0; k < 4; k++) begin
			f.cnt_a[k]  = queue_pkg::CNT32_FILL;
			f.cnt_b[k]  = queue_pkg::CNT64_FILL;
			f.cntl_a[k] = queue_pkg::CNT32_FILL;
			f.cntl_b[k] = queue_pkg::CNT64_FILL;
		end
		return f;
	endfunction

	// seeds the forward pipeline, first round needs no query
	function automatic queue_pkg::fwd_out_t fresh_rec(queue_pkg::new_read_t n);
		queue_pkg::fwd_out_t r;
		r.state.status     = queue_pkg::F_INIT;
		r.state.ptr_curr   = '0;
		r.state.read_num   = n.read_num;
		r.state.ik_x0      = n.ik_x0;
		r.state.ik_x1      = n.ik_x1;
		r.state.ik_x2      = n.ik_x2;
		r.state.ik_info    = n.ik_info;
		r.state.forward_i  = n.forward_i + 1'b1;
		r.state.min_intv   = queue_pkg::POS_W'(1);
		r.state.backward_x = n.forward_i;
		r.query            = '0;
		return r;
	endfunction

	// --------------------
	// priority select
	// --------------------

	assign head_break = read_ready && (read_head.status == queue_pkg::F_BREAK);
	assign take_pair  = !head_break && occ_ready && read_ready;
	assign take_fresh = !head_break && !occ_ready && new_read_valid && load_done;

	assign read_pop = reset_n && !stall && (head_break || take_pair);
	assign occ_pop  = reset_n && !stall && take_pair;
	assign new_read = reset_n && !stall && take_fresh;  // loader advances on this

	always_comb begin
		if (head_break) begin
			next_fwd = queue_pkg::unpack_entry(read_head);
			next_occ = occ_out;  // break reads carry no block
		end else if (take_pair) begin
			next_fwd = queue_pkg::unpack_entry(read_head);
			next_occ = occ_head;
		end else if (take_fresh) begin
			next_fwd = fresh_rec(new_read_in);
			next_occ = occ_fill();
		end else begin
			// also covers a block waiting with no read to pair
			next_fwd = bubble_rec();
			next_occ = occ_fill();
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			fwd_out <= bubble_rec();
			occ_out <= occ_fill();
		end else if (!stall) begin
			fwd_out <= next_fwd;
			occ_out <= next_occ;
		end
	end

endmodule

// File: source/seed_queue_top.sv
`timescale 1ns/1ps

module seed_queue_top (
	input  logic                                Clk_32UI,
	input  logic                                reset_n,
	input  logic                                stall,

	input  queue_pkg::fwd_state_t               fwd_in,
	input  logic [queue_pkg::QUERY_W-1:0]       next_query_position,
	input  logic [queue_pkg::QUERY_W-1:0]       query_base,

	input  logic                                dram_get,
	input  queue_pkg::occ_block_t               occ_in,

	input  logic                                new_read_valid,
	input  logic                                load_done,
	input  queue_pkg::new_read_t                new_read_in,

	output logic [queue_pkg::QUERY_W-1:0]       query_position_ram,
	output logic [queue_pkg::READ_NUM_W-1:0]    query_read_num_ram,
	output logic [queue_pkg::STATUS_W-1:0]      query_status_ram,

	output logic                                new_read,
	output queue_pkg::fwd_out_t                 fwd_out,
	output queue_pkg::occ_block_t               occ_out
);

	queue_pkg::read_entry_t entry;
	logic                   entry_push;

	queue_pkg::read_entry_t read_head;
	logic                   read_ready;
	logic                   read_pop;

	queue_pkg::occ_block_t  occ_head;
	logic                   occ_ready;
	logic                   occ_pop;

	query_align i_query_align (
		.Clk_32UI            (Clk_32UI),
		.fwd_in              (fwd_in),
		.next_query_position (next_query_position),
		.query_base          (query_base),
		.query_position_ram  (query_position_ram),
		.query_read_num_ram  (query_read_num_ram),
		.query_status_ram    (query_status_ram),
		.entry               (entry),
		.entry_push          (entry_push)
	);

	// parked reads, write side never stalls
	circular_queue #(
		.payload_t (queue_pkg::read_entry_t),
		.DEPTH     (queue_pkg::READ_Q_DEPTH)
	) read_queue (
		.Clk_32UI  (Clk_32UI),
		.reset_n   (reset_n),
		.push      (entry_push),
		.pop       (read_pop),
		.din       (entry),
		.head      (read_head),
		.not_empty (read_ready)
	);

	circular_queue #(
		.payload_t (queue_pkg::occ_block_t),
		.DEPTH     (queue_pkg::OCC_Q_DEPTH)
	) occ_queue (
		.Clk_32UI  (Clk_32UI),
		.reset_n   (reset_n),
		.push      (dram_get),  // DRAM response strobe
		.pop       (occ_pop),
		.din       (occ_in),
		.head      (occ_head),
		.not_empty (occ_ready)
	);

	read_dispatch i_read_dispatch (
		.Clk_32UI       (Clk_32UI),
		.reset_n        (reset_n),
		.stall          (stall),
		.read_head      (read_head),
		.read_ready     (read_ready),
		.occ_ready      (occ_ready),
		.occ_head       (occ_head),
		.new_read_valid (new_read_valid),
		.load_done      (load_done),
		.new_read_in    (new_read_in),
		.read_pop       (read_pop),
		.occ_pop        (occ_pop),
		.new_read       (new_read),
		.fwd_out        (fwd_out),
		.occ_out        (occ_out)
	);

endmodule

// File: verification/seed_queue_assert.sv
`timescale 1ns/1ps

module seed_queue_assert (
	input logic                          Clk_32UI,
	input logic                          reset_n,
	input logic                          stall,
	input logic                          new_read,
	input queue_pkg::fwd_state_t         fwd_in,
	input logic [queue_pkg::QUERY_W-1:0] query_position_ram,
	input queue_pkg::fwd_out_t           fwd_out
);

	int fail_count = 0;

	// loader must never advance while the queue is frozen
	no_fresh_in_stall: assert property (@(posedge Clk_32UI)
		(stall || !reset_n) |-> !new_read)
		else begin
			$error("new_read high during stall or reset");
			fail_count++;
		end

	bubble_no_query: assert property (@(posedge Clk_32UI)
		(fwd_in.status == queue_pkg::BUBBLE) |-> (query_position_ram == '1))
		else begin
			$error("query issued for a bubble");
			fail_count++;
		end

	hold_on_stall: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		stall |=> $stable(fwd_out))
		else begin
			$error("fwd_out changed under stall");
			fail_count++;
		end

endmodule

bind seed_queue_top seed_queue_assert i_seed_queue_assert (.*);

// File: verification/seed_queue_tb.sv
`timescale 1ns/1ps

module seed_queue_tb;

	localparam int NF = 12;  // values kept per golden line

	logic Clk_32UI;
	logic reset_n;
	logic stall;
	logic dram_get;
	logic new_read_valid;
	logic load_done;
	logic new_read;
	queue_pkg::fwd_state_t fwd_in;
	queue_pkg::occ_block_t occ_in;
	queue_pkg::occ_block_t occ_out;
	queue_pkg::new_read_t new_read_in;
	queue_pkg::fwd_out_t fwd_out;
	logic [queue_pkg::QUERY_W-1:0] next_query_position;
	logic [queue_pkg::QUERY_W-1:0] query_base;
	logic [queue_pkg::QUERY_W-1:0] query_position_ram;
	logic [queue_pkg::READ_NUM_W-1:0] query_read_num_ram;
	logic [queue_pkg::STATUS_W-1:0] query_status_ram;

	string op_tag [$];
	logic [63:0] op_val [$];
	logic [63:0] exp_val [$];
	logic [7:0] ram_d1;
	logic [7:0] ram_d2;
	logic out_updated = 1'b0;
	int exp_idx = 0;
	int errors = 0;
	int checks = 0;
	int reads_offered = 0;
	int reads_taken = 0;
	int cycles = 0;
	int limit = 0;
	integer seed = 32'h1844_5d72;

	seed_queue_top i_dut (.*);

	initial Clk_32UI = 1'b0;
	always #20 Clk_32UI = ~Clk_32UI;

	// read RAM model, three cycles of latency
	always @(posedge Clk_32UI) begin
		ram_d1     <= query_position_ram ^ query_read_num_ram[7:0];
		ram_d2     <= ram_d1;
		query_base <= ram_d2;
	end

	always @(posedge Clk_32UI) begin
		out_updated <= reset_n && !stall;  // fwd_out reloads on this edge
		if (new_read) begin
			new_read_valid <= 1'b0;
			reads_taken++;
		end
	end

	// --------------------
	// helpers
	// --------------------

	function automatic queue_pkg::fwd_state_t idle_state();
		queue_pkg::fwd_state_t s;
		s = '0;
		s.status = queue_pkg::BUBBLE;
		return s;
	endfunction

	function automatic queue_pkg::occ_block_t occ_pattern(logic [7:0] id);
		queue_pkg::occ_block_t o;
		for (int k = 0; k < 4; k++) begin
			o.cnt_a[k]  = {8'ha0, id, 8'h00, 8'(k)};
			o.cnt_b[k]  = {8'hb0, id, 40'h0, 8'(k)};
			o.cntl_a[k] = {8'hc0, id, 8'h00, 8'(k)};
			o.cntl_b[k] = {8'hd0, id, 40'h0, 8'(k)};
		end
		return o;
	endfunction

	task automatic compare_field(string name, logic [63:0] got, logic [63:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("error %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_record();
		int b;
		b = exp_idx * NF;
		if (b >= exp_val.size()) begin
			$display("record for read %h came out with nothing left to expect",
				fwd_out.state.read_num);
			errors++;
		end else begin
			compare_field("fwd_out.state.status", fwd_out.state.status, exp_val[b]);
			compare_field("fwd_out.state.ptr_curr", fwd_out.state.ptr_curr, exp_val[b+1]);
			compare_field("fwd_out.state.read_num", fwd_out.state.read_num, exp_val[b+2]);
			compare_field("fwd_out.state.ik_x0", fwd_out.state.ik_x0, exp_val[b+3]);
			compare_field("fwd_out.state.ik_x1", fwd_out.state.ik_x1, exp_val[b+4]);
			compare_field("fwd_out.state.ik_x2", fwd_out.state.ik_x2, exp_val[b+5]);
			compare_field("fwd_out.state.ik_info", fwd_out.state.ik_info, exp_val[b+6]);
			compare_field("fwd_out.state.forward_i", fwd_out.state.forward_i, exp_val[b+7]);
			compare_field("fwd_out.state.min_intv", fwd_out.state.min_intv, exp_val[b+8]);
			compare_field("fwd_out.state.backward_x", fwd_out.state.backward_x, exp_val[b+9]);
			compare_field("fwd_out.query", fwd_out.query, exp_val[b+10]);
			if (exp_val[b+11] != 0) begin  // paired read, block must match
				checks++;
				assert (occ_out == occ_pattern(exp_val[b+11][7:0])) else begin
					$display("error %0t occ_out got %h expected %h", $time, occ_out,
						occ_pattern(exp_val[b+11][7:0]));
					errors++;
				end
			end
			exp_idx++;
		end
	endtask

	always @(negedge Clk_32UI) begin
		if (out_updated && fwd_out.state.status != queue_pkg::BUBBLE) check_record();
	end

	always @(posedge Clk_32UI) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, %0d expected records never came out",
				cycles, exp_val.size() / NF - exp_idx);
			$display("checks %0d errors %0d assertion failures %0d", checks, errors + 1,
				i_dut.i_seed_queue_assert.fail_count);
			$display("sim failed");
			$finish;
		end
	end

	// --------------------
	// stimulus
	// --------------------

	initial begin
		integer fd;
		integer r;
		int n_lines;
		int b;
		int stall_len;
		string tag;
		string line;
		logic [63:0] v [NF];
		queue_pkg::fwd_state_t s;
		queue_pkg::new_read_t n;
		reset_n = 1'b0;
		stall = 1'b0;
		dram_get = 1'b0;
		new_read_valid = 1'b0;
		load_done = 1'b0;
		fwd_in = idle_state();
		occ_in = '0;
		new_read_in = '0;
		next_query_position = '0;
		query_base = '0;
		n_lines = 0;
		fd = $fopen("verification/seed_queue_golden.txt", "r");
		if (fd == 0) begin
			$display("golden file could not be opened");
			$display("sim failed");
			$finish;
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			n_lines++;
			foreach (v[k]) v[k] = '0;
			if (tag == "#") begin
				r = $fgets(line, fd);
			end else begin
				b = (tag == "S") ? 11 : (tag == "O") ? 1 : (tag == "N") ? 6 :
					(tag == "E") ? 12 : 0;
				for (int k = 0; k < b; k++) r = $fscanf(fd, "%h", v[k]);
				if (tag == "E") begin
					foreach (v[k]) exp_val.push_back(v[k]);
				end else begin
					op_tag.push_back(tag);
					foreach (v[k]) op_val.push_back(v[k]);
				end
			end
		end
		$fclose(fd);
		limit = 20 * n_lines + 200;

		repeat (8) @(posedge Clk_32UI);
		// loader offers while the queue is still held in reset
		new_read_valid <= 1'b1;
		load_done <= 1'b1;
		repeat (4) @(posedge Clk_32UI);
		new_read_valid <= 1'b0;
		repeat (4) @(posedge Clk_32UI);
		reset_n <= 1'b1;
		repeat (4) @(posedge Clk_32UI);
		@(negedge Clk_32UI);
		compare_field("fwd_out.state.status", fwd_out.state.status, queue_pkg::BUBBLE);
		compare_field("new_read", new_read, 1'b0);

		for (int i = 0; i < op_tag.size(); i++) begin
			b = i * NF;
			@(posedge Clk_32UI);
			if (op_tag[i] == "S") begin
				s = {op_val[b][5:0], op_val[b+1][6:0], op_val[b+2][9:0], op_val[b+3],
					op_val[b+4], op_val[b+5], op_val[b+6], op_val[b+7][6:0],
					op_val[b+8][6:0], op_val[b+9][6:0]};
				fwd_in <= s;
				next_query_position <= op_val[b+10][7:0];
				@(negedge Clk_32UI);
				// break reads send an all-ones status to the RAM
				compare_field("query_status_ram", query_status_ram,
					(op_val[b][5:0] == queue_pkg::F_BREAK) ? 64'h3f : op_val[b][5:0]);
				@(posedge Clk_32UI);
				fwd_in <= idle_state();
			end else if (op_tag[i] == "O") begin
				occ_in <= occ_pattern(op_val[b][7:0]);
				dram_get <= 1'b1;
				@(posedge Clk_32UI);
				dram_get <= 1'b0;
			end else if (op_tag[i] == "N") begin
				n = {op_val[b][9:0], op_val[b+1], op_val[b+2], op_val[b+3], op_val[b+4],
					op_val[b+5][6:0]};
				new_read_in <= n;
				new_read_valid <= 1'b1;  // dropped again once new_read is seen
				reads_offered++;
			end else if (op_tag[i] == "T") begin
				stall_len = 70 + ($random(seed) & 15);
				fork
					begin
						stall <= 1'b1;
						repeat (stall_len) @(posedge Clk_32UI);
						stall <= 1'b0;
					end
				join_none
			end
			repeat (8 + ($random(seed) & 7)) @(posedge Clk_32UI);
		end

		while (exp_idx < exp_val.size() / NF || new_read_valid || stall) begin
			@(posedge Clk_32UI);
		end
		repeat (20) @(posedge Clk_32UI);
		checks++;
		assert (reads_taken == reads_offered) else begin
			$display("error %0t new_read got %0d expected %0d", $time, reads_taken,
				reads_offered);
			errors++;
		end
		$display("checks %0d errors %0d assertion failures %0d", checks, errors,
			i_dut.i_seed_queue_assert.fail_count);
		if (errors == 0 && i_dut.i_seed_queue_assert.fail_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: verification/seed_queue_golden.txt
# S status ptr read_num ik_x0 ik_x1 ik_x2 ik_info forward_i min_intv backward_x position
# O block_id | N read_num ik_x0 ik_x1 ik_x2 ik_info forward_i | T stall window
# E status ptr read_num ik_x0 ik_x1 ik_x2 ik_info forward_i min_intv backward_x query block_id
N 001 10 20 30 40 05
E 00 00 001 10 20 30 40 06 01 05 00 00
N 002 0123456789abcdef fedcba9876543210 0f0f0f0f0f0f0f0f 8000000000000001 7f
E 00 00 002 0123456789abcdef fedcba9876543210 0f0f0f0f0f0f0f0f 8000000000000001 00 01 7f 00 00
S 02 03 011 0000000400000012 00000001ffffffff ffffffffffffffff ff0000ff000000ff 10 02 08 55
E 02 03 011 12 00000001ffffffff 00000001ffffffff 0000007f0000007f 10 02 08 00 00
S 01 04 021 100 200 300 0000002a00000015 11 03 09 3c
O 01
E 01 04 021 100 200 300 0000002a00000015 11 03 09 1d 01
# two blocks waiting, paired in arrival order
O 04
O 05
S 00 05 051 0000000100000001 5 6 7 12 01 0a 77
S 01 06 3ff fffffffe00000000 0 1 0000008000000080 13 02 0b a5
E 00 05 051 0000000100000001 5 6 7 12 01 0a 26 04
E 01 06 3ff 0 0 1 0 13 02 0b 5a 05
# waiting block holds back the fresh read, break goes first
O 06
N 003 1 2 3 4 00
S 02 01 012 aaaa bbbb cccc dddd 20 04 0c 11
S 01 07 061 11 22 33 44 21 05 0d 60
E 02 01 012 aaaa bbbb cccc 5d 20 04 0c 00 00
E 01 07 061 11 22 33 44 21 05 0d 01 06
E 00 00 003 1 2 3 4 01 01 00 00 00
S 20 00 0c0 1 1 1 1 01 01 01 00
# stall window with traffic arriving underneath
T
S 02 02 0a0 1 2 3 4 30 01 10 00
S 01 08 071 7 8 9 a 31 02 11 0f
O 07
S 02 09 0b0 b c d e 32 03 12 00
E 02 02 0a0 1 2 3 4 30 01 10 00 00
E 01 08 071 7 8 9 a 31 02 11 7e 07
E 02 09 0b0 b c d e 32 03 12 00 00
N 004 9 9 9 9 40
E 00 00 004 9 9 9 9 41 01 40 00 00

// File: all.f
source/queue_pkg.sv
source/query_align.sv
source/circular_queue.sv
source/read_dispatch.sv
source/seed_queue_top.sv
verification/seed_queue_assert.sv
verification/seed_queue_tb.sv
